// File: verilog.f
hdl/mips_pkg.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_control.sv
hdl/mips_cpu_bus.sv
test/mips_memory_model.sv
test/mips_cpu_checker.sv
test/mips_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mips_tb
BUILD_DIR ?= build

VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/100ps

# Sources are read from the file list so the binary tracks every file in it
SOURCES := $(shell grep -v '^+' verilog.f)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): verilog.f $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f verilog.f

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

// File: test/mips_tb.sv
module mips_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    localparam word_t     RESET_VECTOR = 32'hBFC0_0000;
    localparam int        RTYPE_PAIRS  = 20;
    localparam int        IMM_TESTS    = 20;
    localparam int        MEM_TESTS    = 10;
    localparam int        NUM_TESTS    = 9 * RTYPE_PAIRS + 6 * IMM_TESTS + MEM_TESTS + 6;
    localparam int        CYCLE_LIMIT  = NUM_TESTS * 200;
    localparam reg_addr_t REG_T0       = 5'd8;
    localparam reg_addr_t REG_T1       = 5'd9;

    logic       clk = 1'b0;
    logic       reset;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       read;
    logic       write;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;
    logic       load_en;
    logic [8:0] load_index;
    word_t      load_data;
    word_t      last_write_addr;
    word_t      last_write_data;

    word_t  prog [$];
    integer seed = 32'h3fa3_d9c1;
    int     cycles = 0;

    // Expected results for the compare process
    word_t expected_v0;
    logic  check_write;
    word_t expected_addr;
    word_t expected_data;
    string test_name;
    event  result_ready;

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("TB FAILED");
            $fatal(1, "Cycle limit reached");
        end
    end

    // Bus protocol failures seen by the bound checker
    always @(i_dut.i_checker.failures) begin
        if (i_dut.i_checker.failures != 0) begin
            $display("A bus protocol assertion failed at %0t", $time);
            $display("TB FAILED");
            $fatal(1, "Checker assertion failed");
        end
    end

    mips_cpu_bus #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    mips_memory_model #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_mem (
        .clk             (clk),
        .reset           (reset),
        .address         (address),
        .read            (read),
        .write           (write),
        .writedata       (writedata),
        .byteenable      (byteenable),
        .waitrequest     (waitrequest),
        .readdata        (readdata),
        .load_en         (load_en),
        .load_index      (load_index),
        .load_data       (load_data),
        .last_write_addr (last_write_addr),
        .last_write_data (last_write_data)
    );

    task automatic check_word(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Wrong word value");
        end
    endtask

    task automatic check_active(bit actual, bit expected, string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Wrong bit value");
        end
    endtask

    // Expected $v0 straight from the MIPS instruction rules
    function automatic word_t mips_ref(opcode_t op, logic [5:0] fn, word_t a, word_t b,
                                       logic [4:0] sh);
        word_t imm_s;
        word_t imm_z;
        imm_z = {16'h0000, b[15:0]};
        imm_s = {{16{b[15]}}, b[15:0]};
        case (op)
            OPCODE_R: begin
                case (fn)
                    FUNCTION_ADDU: return a + b;
                    FUNCTION_SUBU: return a + ~b + 32'd1;
                    FUNCTION_AND:  return a & b;
                    FUNCTION_OR:   return a | b;
                    FUNCTION_XOR:  return a ^ b;
                    FUNCTION_SLT: begin
                        // Opposite signs decide by the sign bit alone
                        if (a[31] != b[31]) return {31'd0, a[31]};
                        return {31'd0, a < b};
                    end
                    FUNCTION_SLTU: return {31'd0, a < b};
                    FUNCTION_SLL:  return b << sh;
                    FUNCTION_SRL:  return b >> sh;
                    default:       return '0;
                endcase
            end
            OPCODE_ADDIU: return a + imm_s;
            OPCODE_SLTI: begin
                if (a[31] != imm_s[31]) return {31'd0, a[31]};
                return {31'd0, a < imm_s};
            end
            OPCODE_ANDI: return a & imm_z;
            OPCODE_ORI:  return a | imm_z;
            OPCODE_XORI: return a ^ imm_z;
            OPCODE_LUI:  return {b[15:0], 16'h0000};
            default:     return '0;
        endcase
    endfunction

    function automatic word_t r_format(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                       logic [4:0] sh, function_t fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_format(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                       logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_format(opcode_t op, word_t target);
        return {op, target[27:2]};
    endfunction

    task automatic emit(word_t w);
        prog.push_back(w);
    endtask

    task automatic load_constant(reg_addr_t r, word_t value);
        emit(i_format(OPCODE_LUI, 5'd0, r, value[31:16]));
        emit(i_format(OPCODE_ORI, r, r, value[15:0]));
    endtask

    // Jump to address zero with a no-op in the delay slot
    task automatic append_halt();
        emit(r_format(5'd0, 5'd0, 5'd0, 5'd0, FUNCTION_JR));
        emit(32'h0000_0000);
    endtask

    // Program words go into memory one per reset cycle
    task automatic run_program();
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 10; i++) begin
            load_en    = (i < prog.size());
            load_index = 9'(i);
            load_data  = (i < prog.size()) ? prog[i] : 32'h0000_0000;
            @(negedge clk);
        end
        load_en = 1'b0;
        reset   = 1'b0;
        prog.delete();
        while (active) @(negedge clk);
    endtask

    task automatic request_compare(word_t expected, string name);
        expected_v0 = expected;
        test_name   = name;
        -> result_ready;
        @(posedge clk);
        check_write = 1'b0;
    endtask

    always @(result_ready) begin
        check_word(register_v0, expected_v0, {test_name, " $v0"});
        if (check_write) begin
            check_word(last_write_addr, expected_addr, {test_name, " write address"});
            check_word(last_write_data, expected_data, {test_name, " write data"});
        end
    end

    task automatic test_rtype(function_t fn, string name);
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        for (int n = 0; n < RTYPE_PAIRS; n++) begin
            a  = $random(seed);
            b  = $random(seed);
            sh = (fn == FUNCTION_SLL || fn == FUNCTION_SRL) ? a[4:0] : 5'd0;
            load_constant(REG_T0, a);
            load_constant(REG_T1, b);
            emit(r_format(REG_T0, REG_T1, REG_V0, sh, fn));
            append_halt();
            run_program();
            request_compare(mips_ref(OPCODE_R, fn, a, b, sh), name);
        end
    endtask

    task automatic test_immediate(opcode_t op, string name);
        word_t       a;
        word_t       r;
        logic [15:0] imm;
        reg_addr_t   src;
        for (int n = 0; n < IMM_TESTS; n++) begin
            a   = $random(seed);
            r   = $random(seed);
            imm = r[15:0];
            // Every other immediate is negative
            if (n % 2 == 1) imm[15] = 1'b1;
            src = (op == OPCODE_LUI) ? 5'd0 : REG_T0;
            load_constant(REG_T0, a);
            emit(i_format(op, src, REG_V0, imm));
            append_halt();
            run_program();
            request_compare(mips_ref(op, 6'h00, a, {16'h0000, imm}, 5'd0), name);
        end
    endtask

    task automatic test_store_load();
        word_t       r;
        word_t       base;
        word_t       data;
        logic [15:0] offset;
        for (int n = 0; n < MEM_TESTS; n++) begin
            r      = $random(seed);
            data   = $random(seed);
            base   = 32'h100 + {23'h0, r[8:2], 2'b00};
            offset = {{9{r[20]}}, r[19:15], 2'b00};
            load_constant(REG_T0, base);
            load_constant(REG_T1, data);
            emit(i_format(OPCODE_SW, REG_T0, REG_T1, offset));
            emit(i_format(OPCODE_LW, REG_T0, REG_V0, offset));
            append_halt();
            run_program();
            check_write   = 1'b1;
            expected_addr = base + {{16{offset[15]}}, offset};
            expected_data = data;
            request_compare(data, "SW then LW");
        end
    endtask

    // The delay slot adds 3 and the fall-through adds 40
    // A taken branch lands on the halt
    task automatic test_branch(opcode_t op, logic equal, string name);
        logic taken;
        emit(i_format(OPCODE_ADDIU, 5'd0, REG_T0, 16'd5));
        emit(i_format(OPCODE_ADDIU, 5'd0, REG_T1, equal ? 16'd5 : 16'd6));
        emit(i_format(OPCODE_ADDIU, 5'd0, REG_V0, 16'd0));
        emit(i_format(op, REG_T0, REG_T1, 16'd2));
        emit(i_format(OPCODE_ADDIU, REG_V0, REG_V0, 16'd3));
        emit(i_format(OPCODE_ADDIU, REG_V0, REG_V0, 16'd40));
        append_halt();
        run_program();
        taken = (op == OPCODE_BEQ) ? equal : !equal;
        request_compare(taken ? 32'd3 : 32'd43, name);
    endtask

    task automatic test_jump();
        emit(j_format(OPCODE_J, RESET_VECTOR + 32'd12));
        emit(i_format(OPCODE_ADDIU, 5'd0, REG_V0, 16'd21));
        emit(i_format(OPCODE_ADDIU, 5'd0, REG_V0, 16'd99));
        append_halt();
        run_program();
        request_compare(32'd21, "J over instruction");
    endtask

    task automatic test_halt();
        emit(i_format(OPCODE_ADDIU, 5'd0, REG_V0, 16'd77));
        append_halt();
        run_program();
        request_compare(32'd77, "halt program");
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_active(active, 1'b0, "active after halt");
            check_active(read, 1'b0, "read after halt");
            check_active(write, 1'b0, "write after halt");
        end
    endtask

    initial begin
        reset       = 1'b1;
        load_en     = 1'b0;
        load_index  = '0;
        load_data   = '0;
        check_write = 1'b0;
        test_rtype(FUNCTION_ADDU, "ADDU");
        test_rtype(FUNCTION_SUBU, "SUBU");
        test_rtype(FUNCTION_AND, "AND");
        test_rtype(FUNCTION_OR, "OR");
        test_rtype(FUNCTION_XOR, "XOR");
        test_rtype(FUNCTION_SLT, "SLT");
        test_rtype(FUNCTION_SLTU, "SLTU");
        test_rtype(FUNCTION_SLL, "SLL");
        test_rtype(FUNCTION_SRL, "SRL");
        test_immediate(OPCODE_ADDIU, "ADDIU");
        test_immediate(OPCODE_ANDI, "ANDI");
        test_immediate(OPCODE_ORI, "ORI");
        test_immediate(OPCODE_XORI, "XORI");
        test_immediate(OPCODE_SLTI, "SLTI");
        test_immediate(OPCODE_LUI, "LUI");
        test_store_load();
        test_branch(OPCODE_BEQ, 1'b1, "BEQ taken");
        test_branch(OPCODE_BEQ, 1'b0, "BEQ not taken");
        test_branch(OPCODE_BNE, 1'b0, "BNE taken");
        test_branch(OPCODE_BNE, 1'b1, "BNE not taken");
        test_jump();
        test_halt();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: test/mips_cpu_checker.sv
module mips_cpu_checker (
    input logic            clk,
    input logic            reset,
    input logic            active,
    input logic            read,
    input logic            write,
    input logic            waitrequest,
    input mips_pkg::word_t address,
    input mips_pkg::word_t writedata,
    input logic [3:0]      byteenable
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed properties so far
    int failures = 0;

    exclusive_request: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            failures = failures + 1;
            $error("read and write are high in the same cycle");
        end

    // A stalled request keeps its address and strobes
    stable_request: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else begin
            failures = failures + 1;
            $error("request changed while waitrequest was high");
        end

    stable_writedata: assert property (@(posedge clk) disable iff (reset)
        write && waitrequest |=> $stable(writedata))
        else begin
            failures = failures + 1;
            $error("writedata changed while waitrequest was high");
        end

    full_word: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> (byteenable == 4'b1111))
        else begin
            failures = failures + 1;
            $error("byteenable is not all ones during a request");
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
        !active |-> (!read && !write))
        else begin
            failures = failures + 1;
            $error("bus request issued after the core halted");
        end

    halt_is_final: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active)
        else begin
            failures = failures + 1;
            $error("active rose again without a reset");
        end

endmodule

bind mips_cpu_bus mips_cpu_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable)
);

// File: test/mips_memory_model.sv
module mips_memory_model #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    output logic            waitrequest,
    output mips_pkg::word_t readdata,
    input  logic            load_en,
    input  logic [8:0]      load_index,
    input  mips_pkg::word_t load_data,
    output mips_pkg::word_t last_write_addr,
    output mips_pkg::word_t last_write_data
);
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    // Lower half holds data, upper half holds the program
    word_t       mem [0:1023];
    logic [1:0]  wait_left;
    logic [31:0] rnd;
    integer      seed = 32'h3fa3_d9c1;

    function automatic logic [9:0] word_index(word_t addr);
        word_t offset;
        if (addr >= RESET_VECTOR) begin
            offset = addr - RESET_VECTOR;
            return {1'b1, offset[10:2]};
        end
        return {1'b0, addr[10:2]};
    endfunction

    assign waitrequest = (read || write) && (wait_left != 2'd0);
    assign readdata    = mem[word_index(address)];

    always @(posedge clk) begin
        if (reset) begin
            rnd = $random(seed);
            wait_left       <= rnd[1:0];
            last_write_addr <= '0;
            last_write_data <= '0;
            if (load_en) begin
                mem[{1'b1, load_index}] <= load_data;
            end
        end else if (read || write) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                // Draw the stall for the next request once this transfer completes
                rnd = $random(seed);
                wait_left <= rnd[1:0];
                if (write) begin
                    // Only the enabled byte lanes are written
                    for (int lane = 0; lane < 4; lane++) begin
                        if (byteenable[lane]) begin
                            mem[word_index(address)][8*lane +: 8] <= writedata[8*lane +: 8];
                        end
                    end
                    last_write_addr <= address;
                    last_write_data <= writedata;
                end
            end
        end
    end

endmodule

// File: hdl/mips_cpu_bus.sv
module mips_cpu_bus #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic           clk,
    input  logic           reset,
    output logic           active,
    output mips_pkg::word_t register_v0,

    // Avalon memory-mapped master
    output mips_pkg::word_t address,
    output logic           write,
    output logic           read,
    input  logic           waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]     byteenable,
    input  mips_pkg::word_t readdata
);
    import mips_pkg::*;

    word_t     instr;
    word_t     pc;
    word_t     rs_data;
    word_t     rt_data;
    word_t     result;
    reg_addr_t dest;
    logic      writes_reg;
    logic      branch_taken;
    word_t     branch_target;
    logic      is_load;
    logic      is_store;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    mips_regfile i_regfile (
        .clk         (clk),
        .rs_addr     (instr[25:21]),
        .rt_addr     (instr[20:16]),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    mips_alu i_alu (
        .instr         (instr),
        .pc            (pc),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .result        (result),
        .dest          (dest),
        .writes_reg    (writes_reg),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .is_load       (is_load),
        .is_store      (is_store)
    );

    mips_control #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_control (
        .clk           (clk),
        .reset         (reset),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .writes_reg    (writes_reg),
        .branch_taken  (branch_taken),
        .is_load       (is_load),
        .is_store      (is_store),
        .result        (result),
        .dest          (dest),
        .branch_target (branch_target),
        .rt_data       (rt_data),
        .instr         (instr),
        .pc            (pc),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .active        (active),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable)
    );

endmodule

// File: hdl/mips_control.sv
module mips_control #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               waitrequest,
    input  mips_pkg::word_t     readdata,
    input  logic               writes_reg,
    input  logic               branch_taken,
    input  logic               is_load,
    input  logic               is_store,
    input  mips_pkg::word_t     result,
    input  mips_pkg::reg_addr_t dest,
    input  mips_pkg::word_t     branch_target,
    input  mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     instr,
    output mips_pkg::word_t     pc,
    output logic               wr_en,
    output mips_pkg::reg_addr_t wr_addr,
    output mips_pkg::word_t     wr_data,
    output logic               active,
    output mips_pkg::word_t     address,
    output logic               read,
    output logic               write,
    output mips_pkg::word_t     writedata,
    output logic [3:0]         byteenable
);
    import mips_pkg::*;

    state_t state;
    word_t  ir;
    word_t  pending_target;
    logic   delay;
    word_t  pc_next;
    logic   fetch_done;
    logic   mem_done;
    logic   is_mem;

    assign instr = ir;

    assign is_mem     = is_load || is_store;
    assign fetch_done = (state == FETCH) && !waitrequest;
    assign mem_done   = (state == MEM) && !waitrequest;

    // The delay slot runs from pc + 4 and the stored target follows it
    always_comb begin
        if (delay) begin
            pc_next = pending_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= RESET_VECTOR;
            delay <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (fetch_done) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    pc    <= pc_next;
                    delay <= branch_taken;
                    if (is_mem) begin
                        state <= MEM;
                    end else if (pc_next == '0) begin
                        // Next fetch would be at zero
                        state <= HALTED;
                    end else begin
                        state <= FETCH;
                    end
                end
                MEM: begin
                    // pc already points at the next instruction here
                    if (mem_done) begin
                        state <= (pc == '0) ? HALTED : FETCH;
                    end
                end
                default: state <= HALTED;
            endcase
        end
    end

    // Instruction word and branch target
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            ir <= readdata;
        end
        if ((state == EXEC) && branch_taken) begin
            pending_target <= branch_target;
        end
    end

    // Register write port
    assign wr_en   = ((state == EXEC) && writes_reg) || (mem_done && is_load);
    assign wr_addr = dest;
    assign wr_data = (state == MEM) ? readdata : result;

    // Avalon master, driven from the state
    assign read       = (state == FETCH) || ((state == MEM) && is_load);
    assign write      = (state == MEM) && is_store;
    assign address    = (state == FETCH) ? pc : result;
    assign writedata  = rt_data;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;

    assign active = (state != HALTED);

endmodule

// File: hdl/mips_alu.sv
module mips_alu (
    input  mips_pkg::word_t     instr,
    input  mips_pkg::word_t     pc,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     result,
    output mips_pkg::reg_addr_t dest,
    output logic               writes_reg,
    output logic               branch_taken,
    output mips_pkg::word_t     branch_target,
    output logic               is_load,
    output logic               is_store
);
    import mips_pkg::*;

    opcode_t              opcode;
    function_t            funct;
    reg_addr_t            rt;
    reg_addr_t            rd;
    logic [4:0]           shamt;
    logic [IMM_WIDTH-1:0] imm;
    logic [25:0]          index;
    word_t                imm_sext;
    word_t                imm_zext;
    word_t                pc_plus4;

    assign opcode = opcode_t'(instr[31:26]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = function_t'(instr[5:0]);
    assign imm    = instr[IMM_WIDTH-1:0];
    assign index  = instr[25:0];

    assign imm_sext = {{(WORD_WIDTH - IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
    assign imm_zext = {{(WORD_WIDTH - IMM_WIDTH){1'b0}}, imm};
    assign pc_plus4 = pc + 32'd4;

    assign is_load  = (opcode == OPCODE_LW);
    assign is_store = (opcode == OPCODE_SW);

    always_comb begin
        result        = '0;
        dest          = rt;
        writes_reg    = 1'b0;
        branch_taken  = 1'b0;
        branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
        case (opcode)
            OPCODE_R: begin
                dest       = rd;
                writes_reg = 1'b1;
                case (funct)
                    FUNCTION_ADDU: result = rs_data + rt_data;
                    FUNCTION_SUBU: result = rs_data - rt_data;
                    FUNCTION_AND:  result = rs_data & rt_data;
                    FUNCTION_OR:   result = rs_data | rt_data;
                    FUNCTION_XOR:  result = rs_data ^ rt_data;
                    FUNCTION_SLT:  result = word_t'($signed(rs_data) < $signed(rt_data));
                    FUNCTION_SLTU: result = word_t'(rs_data < rt_data);
                    FUNCTION_SLL:  result = rt_data << shamt;
                    FUNCTION_SRL:  result = rt_data >> shamt;
                    FUNCTION_JR: begin
                        writes_reg    = 1'b0;
                        branch_taken  = 1'b1;
                        branch_target = rs_data;
                    end
                    // Unknown function behaves as a no-op
                    default: writes_reg = 1'b0;
                endcase
            end
            OPCODE_ADDIU: begin
                result     = rs_data + imm_sext;
                writes_reg = 1'b1;
            end
            OPCODE_SLTI: begin
                result     = word_t'($signed(rs_data) < $signed(imm_sext));
                writes_reg = 1'b1;
            end
            OPCODE_ANDI: begin
                result     = rs_data & imm_zext;
                writes_reg = 1'b1;
            end
            OPCODE_ORI: begin
                result     = rs_data | imm_zext;
                writes_reg = 1'b1;
            end
            OPCODE_XORI: begin
                result     = rs_data ^ imm_zext;
                writes_reg = 1'b1;
            end
            OPCODE_LUI: begin
                result     = {imm, 16'h0000};
                writes_reg = 1'b1;
            end
            OPCODE_BEQ: branch_taken = (rs_data == rt_data);
            OPCODE_BNE: branch_taken = (rs_data != rt_data);
            OPCODE_J: begin
                branch_taken  = 1'b1;
                branch_target = {pc_plus4[31:28], index, 2'b00};
            end
            // Effective address for LW and SW
            OPCODE_LW, OPCODE_SW: result = rs_data + imm_sext;
            default: result = '0;
        endcase
    end

endmodule

// File: hdl/mips_regfile.sv
module mips_regfile (
    input  logic               clk,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  logic               wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     register_v0
);
    import mips_pkg::*;

    // $zero has no storage, so only 31 entries
    word_t regs [1:REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read ports
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    assign register_v0 = regs[REG_V0];

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

    // Field widths of a MIPS instruction word
    localparam int WORD_WIDTH   = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int OPCODE_WIDTH = 6;
    localparam int IMM_WIDTH    = 16;

    localparam int REG_COUNT = 32;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Return value register
    localparam reg_addr_t REG_V0 = 5'd2;

    // Primary opcodes handled by the core
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OPCODE_R     = 6'h00,
        OPCODE_J     = 6'h02,
        OPCODE_BEQ   = 6'h04,
        OPCODE_BNE   = 6'h05,
        OPCODE_ADDIU = 6'h09,
        OPCODE_SLTI  = 6'h0a,
        OPCODE_ANDI  = 6'h0c,
        OPCODE_ORI   = 6'h0d,
        OPCODE_XORI  = 6'h0e,
        OPCODE_LUI   = 6'h0f,
        OPCODE_LW    = 6'h23,
        OPCODE_SW    = 6'h2b
    } opcode_t;

    // Function field of R-type instructions
    typedef enum logic [5:0] {
        FUNCTION_SLL  = 6'h00,
        FUNCTION_SRL  = 6'h02,
        FUNCTION_JR   = 6'h08,
        FUNCTION_ADDU = 6'h21,
        FUNCTION_SUBU = 6'h23,
        FUNCTION_AND  = 6'h24,
        FUNCTION_OR   = 6'h25,
        FUNCTION_XOR  = 6'h26,
        FUNCTION_SLT  = 6'h2a,
        FUNCTION_SLTU = 6'h2b
    } function_t;

    // Core sequencing
    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        EXEC   = 2'd1,
        MEM    = 2'd2,
        HALTED = 2'd3
    } state_t;

endpackage
